// ==== rtl/gat_debug_pkg.sv ====
`default_nettype none

package gat_debug_pkg;

  localparam int unsigned CMD_W       = 32;
  localparam int unsigned SPPE_LANES  = 16;
  localparam int unsigned SPPE_W      = 12;
  localparam int unsigned WH_ADDR_W   = 14;
  localparam int unsigned FEAT_ADDR_W = 16;
  localparam int unsigned NUM_SLOTS   = 2;
  localparam int unsigned OP_W        = 2;
  localparam int unsigned REG_IDX_W   = 4;
  localparam int unsigned SLOT_W      = 1;
  localparam int unsigned LANE_W      = $clog2(SPPE_LANES);
  localparam int unsigned FLAGS_W     = 10; // Limit, feature enable, eight handshakes

  localparam logic [FEAT_ADDR_W-1:0] FEAT_ADDR_LIMIT = 16'd43328;
  localparam logic [CMD_W-1:0]       NUM_SPARSE_DATA = 32'd12;
  localparam logic [CMD_W-1:0]       DEBUG_ID        = 32'd13042103;

  localparam logic [OP_W-1:0] OP_NOP   = 2'd0;
  localparam logic [OP_W-1:0] OP_READ  = 2'd1;
  localparam logic [OP_W-1:0] OP_CFG   = 2'd2;
  localparam logic [OP_W-1:0] OP_CLEAR = 2'd3;

  localparam logic [REG_IDX_W-1:0] REG_ID         = 4'd0;
  localparam logic [REG_IDX_W-1:0] REG_CFG        = 4'd1;
  localparam logic [REG_IDX_W-1:0] REG_FLAGS      = 4'd2;
  localparam logic [REG_IDX_W-1:0] REG_SM_COUNT   = 4'd3;
  localparam logic [REG_IDX_W-1:0] REG_FEAT_COUNT = 4'd4;
  localparam logic [REG_IDX_W-1:0] REG_CAP0       = 4'd5;
  localparam logic [REG_IDX_W-1:0] REG_CAP1       = 4'd6;
  localparam logic [REG_IDX_W-1:0] REG_CAP_STATUS = 4'd7;

  typedef struct packed {
    logic [OP_W-1:0]                    op;
    logic [CMD_W-OP_W-REG_IDX_W-1:0]    rsvd;
    logic [REG_IDX_W-1:0]               reg_idx;
  } dbg_rd_t;

  typedef struct packed {
    logic [OP_W-1:0]                                   op;
    logic [SLOT_W-1:0]                                 slot;
    logic [LANE_W-1:0]                                 lane;
    logic [CMD_W-OP_W-SLOT_W-LANE_W-WH_ADDR_W-1:0]     rsvd;
    logic [WH_ADDR_W-1:0]                              addr;
  } dbg_cfg_t;

  // Same word seen as a register read or as a slot configuration
  typedef union packed {
    dbg_rd_t  rd;
    dbg_cfg_t cfg;
  } dbg_cmd_u;

  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_hs_t;

  typedef struct packed {
    logic                   en;
    logic [FEAT_ADDR_W-1:0] addr;
  } feat_wr_t;

  typedef struct packed {
    logic                 wr;
    logic [SLOT_W-1:0]    slot;
    logic [LANE_W-1:0]    lane;
    logic [WH_ADDR_W-1:0] addr;
  } slot_cfg_t;

  typedef struct packed {
    logic [FLAGS_W-1:0] flags;
    logic [CMD_W-1:0]   sm_count;
    logic [CMD_W-1:0]   feat_count;
  } tracker_obs_t;

  typedef struct packed {
    logic [NUM_SLOTS-1:0][CMD_W-1:0] value;
    logic [NUM_SLOTS-1:0]            valid;
  } capture_obs_t;

endpackage

`default_nettype wire

// ==== rtl/debug_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_cmd_decode (
  input  logic                                        cmd_vld_i,
  input  gat_debug_pkg::dbg_cmd_u                     cmd_i,
  output logic                                        read_vld_o,
  output logic [gat_debug_pkg::REG_IDX_W-1:0]         read_sel_o,
  output gat_debug_pkg::slot_cfg_t                    slot_cfg_o,
  output logic                                        clear_o
);
  import gat_debug_pkg::*;

  logic is_read;
  logic is_cfg;
  logic is_clear;

  // The opcode sits in the same bits of both views
  always_comb begin
    is_read  = 1'b0;
    is_cfg   = 1'b0;
    is_clear = 1'b0;
    case (cmd_i.rd.op)
      OP_READ:  is_read  = 1'b1;
      OP_CFG:   is_cfg   = 1'b1;
      OP_CLEAR: is_clear = 1'b1;
      OP_NOP:   ; // Accepted with no effect
      default:  ;
    endcase
  end

  assign read_vld_o = cmd_vld_i && is_read;
  assign read_sel_o = cmd_i.rd.reg_idx;

  assign slot_cfg_o.wr   = cmd_vld_i && is_cfg;
  assign slot_cfg_o.slot = cmd_i.cfg.slot;
  assign slot_cfg_o.lane = cmd_i.cfg.lane;
  assign slot_cfg_o.addr = cmd_i.cfg.addr;

  assign clear_o = cmd_vld_i && is_clear; // Strobe is one cycle, so is the clear

endmodule

`default_nettype wire

// ==== rtl/stage_event_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_event_tracker (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clear_i,
  input  gat_debug_pkg::stage_hs_t    stage_hs_i,
  input  gat_debug_pkg::feat_wr_t     feat_wr_i,
  output gat_debug_pkg::tracker_obs_t obs_o
);
  import gat_debug_pkg::*;

  logic [FLAGS_W-1:0] flags_q;
  logic [FLAGS_W-1:0] flags_set;
  logic               limit_hit;
  logic [CMD_W-1:0]   sm_count_q;
  logic [CMD_W-1:0]   feat_count_q;

  // Only an enabled write can trip the limit
  assign limit_hit = feat_wr_i.en && (feat_wr_i.addr >= FEAT_ADDR_LIMIT);

  // Bit 9 limit, bit 8 feature enable, bits 7..0 handshakes from spmm valid down
  assign flags_set = {limit_hit, feat_wr_i.en, stage_hs_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else if (clear_i) begin
      flags_q <= '0; // Clear wins over a same-cycle event
    end else begin
      flags_q <= flags_q | flags_set;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_q <= '0;
    end else if (clear_i) begin
      sm_count_q <= '0;
    end else if (stage_hs_i.sm_vld) begin
      sm_count_q <= sm_count_q + CMD_W'(1); // Wraps at full width
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_count_q <= '0;
    end else if (clear_i) begin
      feat_count_q <= '0;
    end else if (feat_wr_i.en) begin
      feat_count_q <= feat_count_q + CMD_W'(1);
    end
  end

  assign obs_o.flags      = flags_q;
  assign obs_o.sm_count   = sm_count_q;
  assign obs_o.feat_count = feat_count_q;

endmodule

`default_nettype wire

// ==== rtl/sppe_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module sppe_capture (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     clear_i,
  input  gat_debug_pkg::slot_cfg_t                 slot_cfg_i,
  input  logic                                     spmm_rdy_i,
  input  logic [gat_debug_pkg::WH_ADDR_W-1:0]      wh_addr_i,
  input  logic [gat_debug_pkg::SPPE_LANES-1:0][gat_debug_pkg::SPPE_W-1:0] sppe_i,
  output gat_debug_pkg::capture_obs_t              obs_o
);
  import gat_debug_pkg::*;

  for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
    logic                 cfg_hit;
    logic                 match;
    logic [WH_ADDR_W-1:0] addr_q;
    logic [LANE_W-1:0]    lane_q;
    logic [CMD_W-1:0]     value_q;
    logic                 valid_q;

    assign cfg_hit = slot_cfg_i.wr && (slot_cfg_i.slot == SLOT_W'(s));
    assign match   = spmm_rdy_i && (wh_addr_i == addr_q);

    // Configuration survives a clear
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        addr_q <= '0;
        lane_q <= '0;
      end else if (cfg_hit) begin
        addr_q <= slot_cfg_i.addr;
        lane_q <= slot_cfg_i.lane;
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        value_q <= '0;
        valid_q <= 1'b0;
      end else if (clear_i) begin
        value_q <= '0;
        valid_q <= 1'b0;
      end else if (cfg_hit) begin
        valid_q <= 1'b0; // New address, old capture no longer belongs to it
      end else if (match) begin
        value_q <= CMD_W'(sppe_i[lane_q]); // Latest match overwrites
        valid_q <= 1'b1;
      end
    end

    assign obs_o.value[s] = value_q;
    assign obs_o.valid[s] = valid_q;
  end

endmodule

`default_nettype wire

// ==== rtl/debug_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_readout (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                read_vld_i,
  input  logic [gat_debug_pkg::REG_IDX_W-1:0] read_sel_i,
  input  gat_debug_pkg::tracker_obs_t         tracker_obs_i,
  input  gat_debug_pkg::capture_obs_t         capture_obs_i,
  output logic                                rsp_vld_o,
  output logic [gat_debug_pkg::CMD_W-1:0]     rsp_data_o
);
  import gat_debug_pkg::*;

  logic [CMD_W-1:0] rsp_word;
  logic             rsp_vld_q;
  logic [CMD_W-1:0] rsp_data_q;

  always_comb begin
    case (read_sel_i)
      REG_ID:         rsp_word = DEBUG_ID;
      REG_CFG:        rsp_word = NUM_SPARSE_DATA;
      REG_FLAGS:      rsp_word = CMD_W'(tracker_obs_i.flags);
      REG_SM_COUNT:   rsp_word = tracker_obs_i.sm_count;
      REG_FEAT_COUNT: rsp_word = tracker_obs_i.feat_count;
      REG_CAP0:       rsp_word = capture_obs_i.value[0];
      REG_CAP1:       rsp_word = capture_obs_i.value[1];
      REG_CAP_STATUS: rsp_word = CMD_W'(capture_obs_i.valid);
      default:        rsp_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= read_vld_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_data_q <= '0;
    end else if (read_vld_i) begin
      rsp_data_q <= rsp_word;
    end
  end

  assign rsp_vld_o  = rsp_vld_q;
  assign rsp_data_o = rsp_data_q;

endmodule

`default_nettype wire

// ==== rtl/gat_debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gat_debug_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cmd_vld_i,
  input  gat_debug_pkg::dbg_cmd_u               cmd_i,
  input  gat_debug_pkg::stage_hs_t              stage_hs_i,
  input  gat_debug_pkg::feat_wr_t               feat_wr_i,
  input  logic [gat_debug_pkg::WH_ADDR_W-1:0]   wh_addr_i,
  input  logic [gat_debug_pkg::SPPE_LANES-1:0][gat_debug_pkg::SPPE_W-1:0] sppe_i,
  output logic                                  rsp_vld_o,
  output logic [gat_debug_pkg::CMD_W-1:0]       rsp_data_o
);
  import gat_debug_pkg::*;

  logic                 read_vld;
  logic [REG_IDX_W-1:0] read_sel;
  slot_cfg_t            slot_cfg;
  logic                 clear;
  tracker_obs_t         tracker_obs;
  capture_obs_t         capture_obs;

  debug_cmd_decode i_debug_cmd_decode (
    .cmd_vld_i  (cmd_vld_i),
    .cmd_i      (cmd_i),
    .read_vld_o (read_vld),
    .read_sel_o (read_sel),
    .slot_cfg_o (slot_cfg),
    .clear_o    (clear)
  );

  stage_event_tracker i_stage_event_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear),
    .stage_hs_i (stage_hs_i),
    .feat_wr_i  (feat_wr_i),
    .obs_o      (tracker_obs)
  );

  // Captures are taken only while spmm accepts data
  sppe_capture i_sppe_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear),
    .slot_cfg_i (slot_cfg),
    .spmm_rdy_i (stage_hs_i.spmm_rdy),
    .wh_addr_i  (wh_addr_i),
    .sppe_i     (sppe_i),
    .obs_o      (capture_obs)
  );

  debug_readout i_debug_readout (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_vld_i    (read_vld),
    .read_sel_i    (read_sel),
    .tracker_obs_i (tracker_obs),
    .capture_obs_i (capture_obs),
    .rsp_vld_o     (rsp_vld_o),
    .rsp_data_o    (rsp_data_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_gat_debug.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gat_debug;
  import gat_debug_pkg::*;

  localparam int          CLK_PERIOD   = 20;
  localparam int          DRIVE_DELAY  = 2;
  localparam int          RESET_CYCLES = 8;
  localparam int          MAX_LINES    = 128;
  localparam int          FIELDS       = 9; // Hex words per stimulus line
  localparam string       STIM_FILE    = "test/gat_debug_stim.txt";

  // Column positions inside one stimulus line
  localparam int F_HS        = 0;
  localparam int F_FEAT_EN   = 1;
  localparam int F_FEAT_ADDR = 2;
  localparam int F_WH_ADDR   = 3;
  localparam int F_SPPE      = 4;
  localparam int F_CMD_VLD   = 5;
  localparam int F_CMD       = 6;
  localparam int F_EXP_VLD   = 7;
  localparam int F_EXP_DATA  = 8;

  logic                              clk;
  logic                              rst_n;
  logic                              cmd_vld;
  dbg_cmd_u                          cmd;
  stage_hs_t                         stage_hs;
  feat_wr_t                          feat_wr;
  logic [WH_ADDR_W-1:0]              wh_addr;
  logic [SPPE_LANES-1:0][SPPE_W-1:0] sppe;
  logic                              rsp_vld;
  logic [CMD_W-1:0]                  rsp_data;

  logic [31:0] stim_mem [0:FIELDS*MAX_LINES-1];
  int          num_lines;
  logic        lines_known;
  int          errors;
  int          checks;

  gat_debug_top i_gat_debug_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld_i  (cmd_vld),
    .cmd_i      (cmd),
    .stage_hs_i (stage_hs),
    .feat_wr_i  (feat_wr),
    .wh_addr_i  (wh_addr),
    .sppe_i     (sppe),
    .rsp_vld_o  (rsp_vld),
    .rsp_data_o (rsp_data)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Unloaded words sit far above any stage_hs byte, which marks the end of the data
  task automatic fill_stim_memory();
    for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
      stim_mem[i] = 32'hbad0_0000 + 32'(i);
    end
  endtask

  function automatic int count_loaded_lines();
    int n;
    n = 0;
    while (n < MAX_LINES && stim_mem[n*FIELDS + F_HS] <= 32'h0000_00ff) begin
      n++;
    end
    return n;
  endfunction

  // Each lane gets the lane number added in the top nibble
  function automatic logic [SPPE_LANES-1:0][SPPE_W-1:0] spread_sppe(
    input logic [SPPE_W-1:0] base
  );
    logic [SPPE_LANES-1:0][SPPE_W-1:0] lanes;
    for (int l = 0; l < SPPE_LANES; l++) begin
      lanes[l] = {base[SPPE_W-1:SPPE_W-4] + 4'(l), base[SPPE_W-5:0]};
    end
    return lanes;
  endfunction

  task automatic idle_inputs();
    cmd_vld  = 1'b0;
    cmd      = '0;
    stage_hs = '0;
    feat_wr  = '0;
    wh_addr  = '0;
    sppe     = '0;
  endtask

  task automatic drive_line(input int line);
    int base;
    base = line * FIELDS;
    stage_hs     = stage_hs_t'(stim_mem[base + F_HS][7:0]);
    feat_wr.en   = stim_mem[base + F_FEAT_EN][0];
    feat_wr.addr = stim_mem[base + F_FEAT_ADDR][FEAT_ADDR_W-1:0];
    wh_addr      = stim_mem[base + F_WH_ADDR][WH_ADDR_W-1:0];
    sppe         = spread_sppe(stim_mem[base + F_SPPE][SPPE_W-1:0]);
    cmd_vld      = stim_mem[base + F_CMD_VLD][0];
    cmd          = stim_mem[base + F_CMD];
  endtask

  // Expected values describe the response seen during this line's cycle
  task automatic check_line(input int line);
    logic             exp_vld;
    logic [CMD_W-1:0] exp_data;
    exp_vld  = stim_mem[line*FIELDS + F_EXP_VLD][0];
    exp_data = stim_mem[line*FIELDS + F_EXP_DATA];
    checks++;
    if (rsp_vld !== exp_vld) begin
      errors++;
      $display("error at %0t: rsp_vld_o expected %0b, got %0b (stim line %0d)",
               $time, exp_vld, rsp_vld, line);
    end
    if (exp_vld && rsp_data !== exp_data) begin
      errors++;
      $display("error at %0t: rsp_data_o expected 0x%08h, got 0x%08h (stim line %0d)",
               $time, exp_data, rsp_data, line);
    end
  endtask

  initial begin : stimulus
    int line;
    $timeformat(-9, 0, " ns", 0);
    errors      = 0;
    checks      = 0;
    num_lines   = 0;
    lines_known = 1'b0;
    rst_n       = 1'b0;
    idle_inputs();
    fill_stim_memory();
    $readmemh(STIM_FILE, stim_mem);
    num_lines   = count_loaded_lines();
    lines_known = 1'b1;
    if (num_lines == 0) begin
      errors++;
      $display("No stimulus lines could be loaded from %s", STIM_FILE);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    for (line = 0; line < num_lines; line++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      drive_line(line);
      @(negedge clk); // Response registers settled half a cycle ago
      check_line(line);
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    idle_inputs();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (lines_known);
    #((num_lines + 20) * CLK_PERIOD);
    $display("Timeout: the run did not end within %0d clock cycles", num_lines + 20);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/gat_debug_stim.txt ====
// Columns: stage_hs feat_en feat_addr wh_addr sppe cmd_vld cmd exp_rsp_vld exp_rsp_data
// The expected response is the one seen during this line, from a read on the line above
00 0 0000 0000 000 0 00000000 0 00000000
00 0 0000 0000 000 0 00000000 0 00000000
00 0 0000 0000 000 1 40000000 0 00000000
00 0 0000 0000 000 1 40000001 1 00C701B7
00 0 0000 0000 000 0 00000000 1 0000000C
00 0 0000 0000 000 0 00000000 0 00000000
80 0 0000 0000 000 0 00000000 0 00000000
00 0 0000 0000 000 1 40000002 0 00000000
00 0 0000 0000 000 0 00000000 1 00000080
04 0 0000 0000 000 0 00000000 0 00000000
01 0 0000 0000 000 0 00000000 0 00000000
00 0 0000 0000 000 1 40000002 0 00000000
00 0 0000 0000 000 0 00000000 1 00000085
20 0 0000 0000 000 1 C0000000 0 00000000
00 0 0000 0000 000 1 40000002 0 00000000
00 0 0000 0000 000 0 00000000 1 00000000
08 0 0000 0000 000 0 00000000 0 00000000
08 0 0000 0000 000 0 00000000 0 00000000
08 0 0000 0000 000 0 00000000 0 00000000
00 0 0000 0000 000 1 40000003 0 00000000
00 0 0000 0000 000 0 00000000 1 00000003
00 1 A93F 0000 000 0 00000000 0 00000000
00 0 0000 0000 000 1 40000002 0 00000000
00 0 0000 0000 000 0 00000000 1 00000108
00 1 A940 0000 000 0 00000000 0 00000000
00 1 0005 0000 000 1 40000004 0 00000000
00 0 0000 0000 000 1 40000002 1 00000002
00 0 0000 0000 000 0 00000000 1 00000308
00 0 0000 0000 000 1 40000004 0 00000000
00 0 0000 0000 000 0 00000000 1 00000003
00 0 0000 0000 000 1 8400000A 0 00000000
00 0 0000 0000 000 1 AA000014 0 00000000
80 0 0000 000A 0AB 0 00000000 0 00000000
00 0 0000 0000 000 1 40000007 0 00000000
00 0 0000 0000 000 0 00000000 1 00000000
40 0 0000 000A 0AB 0 00000000 0 00000000
40 0 0000 0014 0CD 0 00000000 0 00000000
00 0 0000 0000 000 1 40000005 0 00000000
00 0 0000 0000 000 1 40000006 1 000002AB
00 0 0000 0000 000 1 40000007 1 000005CD
00 0 0000 0000 000 0 00000000 1 00000003
40 0 0000 000A 0F1 0 00000000 0 00000000
00 0 0000 0000 000 1 40000005 0 00000000
00 0 0000 0000 000 0 00000000 1 000002F1
00 0 0000 0000 000 1 A200001E 0 00000000
00 0 0000 0000 000 1 40000007 0 00000000
00 0 0000 0000 000 0 00000000 1 00000001
00 0 0000 0000 000 1 C0000000 0 00000000
00 0 0000 0000 000 1 40000007 0 00000000
00 0 0000 0000 000 1 40000005 1 00000000
00 0 0000 0000 000 0 00000000 1 00000000
40 0 0000 001E 033 0 00000000 0 00000000
40 0 0000 000A 044 0 00000000 0 00000000
00 0 0000 0000 000 1 40000006 0 00000000
00 0 0000 0000 000 1 40000005 1 00000133
00 0 0000 0000 000 1 40000007 1 00000244
00 0 0000 0000 000 0 00000000 1 00000003
00 0 0000 0000 000 1 4000000C 0 00000000
00 0 0000 0000 000 1 00000000 1 00000000
00 0 0000 0000 000 0 00000000 0 00000000
00 0 0000 0000 000 0 40000000 0 00000000
00 0 0000 0000 000 0 00000000 0 00000000

// ==== Makefile ====
TOP := tb_gat_debug

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | awk '{ print } /Simulation completed successfully/ { ok = 1 } \
		END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== project.f ====
rtl/gat_debug_pkg.sv
rtl/debug_cmd_decode.sv
rtl/stage_event_tracker.sv
rtl/sppe_capture.sv
rtl/debug_readout.sv
rtl/gat_debug_top.sv
test/tb_gat_debug.sv
